/* tb.f */
+incdir+hw
hw/adder_pkg.sv
hw/harris_prefix_tree.sv
hw/prefix_adder_lane.sv
hw/request_queue.sv
hw/result_select.sv
hw/compound_adder_top.sv
testbench/tb_clock.sv
testbench/tb_compound_adder.sv

/* testbench/tb_compound_adder.sv */
// Compound adder testbench with credit-driven source, random sink and reference queue

`timescale 1ns/1ns
`default_nettype none

`include "adder_consts.svh"

module tb_compound_adder;

	import adder_pkg::*;

	localparam int W = `ADDER_WIDTH;
	localparam int DEPTH = `CREDIT_DEPTH;
	localparam int N_REQ = 200;
	localparam int TIMEOUT = 20 * N_REQ + 200;

	typedef struct packed {
		add_req_t req;
		add_res_t res;
	} ref_entry_t;

	logic       clk;
	logic       rst;
	logic       in_valid;
	add_req_t   in_req;
	logic       in_credit;
	logic       out_credit;
	logic       out_valid;
	add_res_t   out_res;

	add_req_t   stim [N_REQ];
	ref_entry_t ref_q [$];
	ref_entry_t head;
	logic       head_empty;
	logic       seen_request;
	int         n_built;
	int         sent;
	int         received;
	int         src_credits;
	int         sink_credits;
	int         pending;
	int         delay_cnt;
	int         idle_cnt;
	int         cycles;
	int         error_count;

	tb_clock #(.PERIOD(40), .RESET_CYCLES(4)) u_tb_clock (
		.clk (clk),
		.rst (rst)
	);

	compound_adder_top u_compound_adder_top (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_req     (in_req),
		.in_credit  (in_credit),
		.out_credit (out_credit),
		.out_valid  (out_valid),
		.out_res    (out_res)
	);

	// Reference result straight from the arithmetic rules
	function automatic add_res_t expected_result(input add_req_t req);
		logic [W:0] wide;
		add_res_t   res;
		res.tag = req.tag;
		res.neg = 1'b0;
		case (req.op)
			OP_ADD: wide = {1'b0, req.a} + {1'b0, req.b};
			OP_ADD_INC: wide = {1'b0, req.a} + {1'b0, req.b} + 1'b1;
			OP_SUB: wide = {req.a >= req.b, req.a - req.b};
			default: begin
				if (req.a >= req.b) begin
					wide = {1'b1, req.a - req.b};
				end else begin
					wide = {1'b0, req.b - req.a};
					res.neg = 1'b1;
				end
			end
		endcase
		res.sum = wide[W-1:0];
		res.carry = wide[W];
		return res;
	endfunction

	task automatic add_stim(input logic [W-1:0] a, input logic [W-1:0] b, input op_t op);
		stim[n_built].a = a;
		stim[n_built].b = b;
		stim[n_built].op = op;
		stim[n_built].tag = n_built[`TAG_WIDTH-1:0];
		n_built++;
	endtask

	// Mostly short credit delays, now and then a long stall
	function automatic int pick_delay();
		if ($urandom % 8 == 0) begin
			return 30 + $urandom % 30;
		end
		return $urandom % 4;
	endfunction

	initial begin
		logic [W-1:0] same;
		logic [W-1:0] ra;
		void'($urandom(96193));
		in_valid = 1'b0;
		in_req = '0;
		out_credit = 1'b0;
		error_count = 0;
		n_built = 0;
		same = W'($urandom);
		// Carry and borrow corners, each under all four operations
		for (int op = 0; op < 4; op++) begin
			add_stim('1, W'(1), op_t'(op));
			add_stim('1, '0, op_t'(op));
			add_stim(same, same, op_t'(op));
			add_stim('0, '0, op_t'(op));
			add_stim(W'(1) << (W - 1), W'(1), op_t'(op));
			add_stim('0, W'(1), op_t'(op));
		end
		while (n_built < N_REQ) begin
			ra = W'($urandom);
			add_stim(ra, ($urandom % 16 == 0) ? ra : W'($urandom), op_t'($urandom % 4));
		end
	end

	// Source sends only against a held credit
	always @(posedge clk) begin : source_drive
		int credit_now;
		if (rst) begin
			in_valid <= 1'b0;
			src_credits <= DEPTH;
			seen_request <= 1'b0;
			sent = 0;
			idle_cnt = 0;
		end else begin
			credit_now = src_credits + (in_credit ? 1 : 0);
			idle_cnt++;
			if (idle_cnt > 8 && sent < N_REQ && credit_now > 0 && $urandom % 4 != 0) begin
				in_valid <= 1'b1;
				in_req <= stim[sent];
				ref_q.push_back({stim[sent], expected_result(stim[sent])});
				seen_request <= 1'b1;
				sent++;
				credit_now--;
			end else begin
				in_valid <= 1'b0;
			end
			src_credits <= credit_now;
		end
	end

	// Sink takes every result and returns its credit after a random delay
	always @(posedge clk) begin
		if (rst) begin
			out_credit <= 1'b0;
			sink_credits <= DEPTH;
			received = 0;
			pending = 0;
			delay_cnt = 0;
		end else begin
			if (out_valid) begin
				if (ref_q.size() > 0) begin
					void'(ref_q.pop_front());
				end
				received++;
				pending++;
			end
			if (pending > 0 && delay_cnt == 0) begin
				out_credit <= 1'b1;
				pending--;
				delay_cnt = pick_delay();
			end else begin
				out_credit <= 1'b0;
				if (delay_cnt > 0) begin
					delay_cnt--;
				end
			end
			sink_credits <= sink_credits - (out_valid ? 1 : 0) + (out_credit ? 1 : 0);
		end
		head_empty = (ref_q.size() == 0);
		head = head_empty ? '0 : ref_q[0];
	end

	a_idle_before_request: assert property (@(posedge clk) disable iff (rst)
		!seen_request |-> !out_valid && !in_credit)
		else begin
			error_count++;
			$display("FAILED at %0t: output activity before the first request", $time);
		end

	a_no_extra_output: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> !head_empty)
		else begin
			error_count++;
			$display("FAILED at %0t: result with no request outstanding", $time);
		end

	a_result_match: assert property (@(posedge clk) disable iff (rst)
		out_valid && !head_empty |-> out_res == head.res)
		else begin
			error_count++;
			$display("FAILED at %0t: tag %0d got %h expected %h", $time,
				$sampled(head.res.tag), $sampled(out_res), $sampled(head.res));
		end

	a_mag_sign: assert property (@(posedge clk) disable iff (rst)
		out_valid && !head_empty && head.req.op == OP_MAG |->
			out_res.neg == (head.req.a < head.req.b) && (!out_res.neg || out_res.sum != '0))
		else begin
			error_count++;
			$display("FAILED at %0t: magnitude sign wrong for tag %0d", $time,
				$sampled(head.res.tag));
		end

	a_output_credit: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> sink_credits > 0)
		else begin
			error_count++;
			$display("FAILED at %0t: result sent without an output credit", $time);
		end

	a_source_credit: assert property (@(posedge clk) disable iff (rst)
		src_credits >= 0 && src_credits <= DEPTH)
		else begin
			error_count++;
			$display("FAILED at %0t: source credit count %0d out of range", $time,
				$sampled(src_credits));
		end

	always @(posedge clk) begin
		if (rst) begin
			cycles <= 0;
		end else if (cycles >= TIMEOUT) begin
			$display("Run timed out after %0d cycles with %0d of %0d results", cycles,
				received, N_REQ);
			$display("Simulation failed");
			$finish;
		end else begin
			cycles <= cycles + 1;
		end
	end

	initial begin
		@(negedge rst);
		wait (received == N_REQ);
		wait (pending == 0);
		repeat (4) @(posedge clk);
		a_drained: assert (ref_q.size() == 0 && src_credits == DEPTH && sink_credits == DEPTH)
			else begin
				error_count++;
				$display("Run did not drain: %0d expected left, credits %0d and %0d",
					ref_q.size(), src_credits, sink_credits);
			end
		$display("Requests sent %0d, results checked %0d, errors %0d", sent, received,
			error_count);
		if (error_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
// Testbench clock and synchronous reset generator

`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		rst = 1'b1;
	end

	always #(PERIOD / 2) clk = ~clk;

	// Release on a rising edge so the DUT sees a clean synchronous deassert
	initial begin
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

/* hw/compound_adder_top.sv */
// Compound significand adder with credit flow control on both sides

`timescale 1ns/1ns
`default_nettype none

module compound_adder_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	input  adder_pkg::add_req_t in_req,
	output logic                in_credit,
	input  logic                out_credit,
	output logic                out_valid,
	output adder_pkg::add_res_t out_res
);

	import adder_pkg::*;

	logic      issue_valid;
	issue_t    issue;
	lane_out_t sum_lane;
	lane_out_t inc_lane;

	request_queue u_request_queue (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.in_req      (in_req),
		.in_credit   (in_credit),
		.out_credit  (out_credit),
		.issue_valid (issue_valid),
		.issue       (issue)
	);

	// Carry-in 0 lane gives a+b, carry-in 1 lane gives a+b+1
	prefix_adder_lane #(.CARRY_IN(1'b0)) u_sum_lane (
		.clk         (clk),
		.rst         (rst),
		.issue_valid (issue_valid),
		.issue       (issue),
		.lane_out    (sum_lane)
	);

	prefix_adder_lane #(.CARRY_IN(1'b1)) u_inc_lane (
		.clk         (clk),
		.rst         (rst),
		.issue_valid (issue_valid),
		.issue       (issue),
		.lane_out    (inc_lane)
	);

	result_select u_result_select (
		.clk         (clk),
		.rst         (rst),
		.issue_valid (issue_valid),
		.issue       (issue),
		.sum_lane    (sum_lane),
		.inc_lane    (inc_lane),
		.out_valid   (out_valid),
		.out_res     (out_res)
	);

endmodule

`default_nettype wire

/* hw/result_select.sv */
// Result selector that combines the two lane outputs by operation

`timescale 1ns/1ns
`default_nettype none

`include "adder_consts.svh"

module result_select (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 issue_valid,
	input  adder_pkg::issue_t    issue,
	input  adder_pkg::lane_out_t sum_lane,
	input  adder_pkg::lane_out_t inc_lane,
	output logic                 out_valid,
	output adder_pkg::add_res_t  out_res
);

	import adder_pkg::*;

	// Aligned with the lane registers
	logic                  valid_q;
	op_t                   op_q;
	logic [`TAG_WIDTH-1:0] tag_q;
	add_res_t              res_next;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q   <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			valid_q   <= issue_valid;
			out_valid <= valid_q;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_valid) begin
			op_q  <= issue.op;
			tag_q <= issue.tag;
		end
	end

	always_comb begin
		res_next.tag   = tag_q;
		res_next.neg   = 1'b0;
		res_next.sum   = sum_lane.sum;
		res_next.carry = sum_lane.cout;
		case (op_q)
			OP_ADD_INC, OP_SUB: begin
				res_next.sum   = inc_lane.sum;
				res_next.carry = inc_lane.cout;
			end
			OP_MAG: begin
				if (inc_lane.cout) begin
					res_next.sum   = inc_lane.sum;
					res_next.carry = 1'b1;
				end else begin
					// a < b, end-around form gives ~(a + ~b) = b - a
					res_next.sum   = ~sum_lane.sum;
					res_next.carry = 1'b0;
					res_next.neg   = 1'b1;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (valid_q) begin
			out_res <= res_next;
		end
	end

	// A registered issue leaves a fully known result behind it
	a_valid_pipe: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> !$isunknown(out_res))
		else $error("result valid with unknown data");

endmodule

`default_nettype wire

/* hw/request_queue.sv */
// Request FIFO with input credit return, output credit count and operand prep

`timescale 1ns/1ns
`default_nettype none

`include "adder_consts.svh"

module request_queue (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	input  adder_pkg::add_req_t in_req,
	output logic                in_credit,
	input  logic                out_credit,
	output logic                issue_valid,
	output adder_pkg::issue_t   issue
);

	import adder_pkg::*;

	localparam int DEPTH = `CREDIT_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = PTR_W + 1;

	add_req_t           mem [DEPTH];
	add_req_t           head;
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;
	logic [CNT_W-1:0]   credits;
	logic               empty;
	logic               full;
	logic               pop;

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(DEPTH));

	// Pop only against a held output credit, so nothing downstream stalls
	assign pop         = !empty && (credits != '0);
	assign in_credit   = pop;
	assign issue_valid = pop;

	assign head = mem[rd_ptr];

	always_comb begin
		issue.a   = head.a;
		issue.b   = (head.op == OP_SUB || head.op == OP_MAG) ? ~head.b : head.b;
		issue.op  = head.op;
		issue.tag = head.tag;
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			mem[wr_ptr] <= in_req;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (in_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			case ({in_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Downstream grants a full queue's worth of credits at reset
	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= CNT_W'(DEPTH);
		end else begin
			case ({out_credit, pop})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	a_no_push_full: assert property (@(posedge clk) disable iff (rst)
		in_valid |-> !full)
		else $error("request pushed into a full queue");

	a_credit_bound: assert property (@(posedge clk) disable iff (rst)
		credits <= CNT_W'(DEPTH))
		else $error("output credit count above grant");

endmodule

`default_nettype wire

/* hw/prefix_adder_lane.sv */
// Prefix adder lane with fixed carry-in and registered sum and carry-out

`timescale 1ns/1ns
`default_nettype none

`include "adder_consts.svh"

module prefix_adder_lane #(
	parameter logic CARRY_IN = 1'b0
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 issue_valid,
	input  adder_pkg::issue_t    issue,
	output adder_pkg::lane_out_t lane_out
);

	import adder_pkg::*;

	localparam int W = `ADDER_WIDTH;

	// Bit 0 carries the lane carry-in as a generate term
	logic [W:0]   p_ext;
	logic [W:0]   g_ext;
	logic [W:1]   carry;
	lane_out_t    lane_next;

	assign p_ext = {issue.a ^ issue.b, 1'b0};
	assign g_ext = {issue.a & issue.b, CARRY_IN};

	harris_prefix_tree u_tree (
		.p (p_ext[W-1:0]),
		.g (g_ext[W-1:0]),
		.c (carry)
	);

	assign lane_next.sum  = p_ext[W:1] ^ carry;
	assign lane_next.cout = g_ext[W] | (p_ext[W] & carry[W]);

	always_ff @(posedge clk) begin
		if (issue_valid) begin
			lane_out <= lane_next;
		end
	end

	// Queue head must hold real operands whenever it issues
	a_operands_known: assert property (@(posedge clk) disable iff (rst)
		issue_valid |-> !$isunknown({issue.a, issue.b}))
		else $error("lane issued with unknown operands");

endmodule

`default_nettype wire

/* hw/harris_prefix_tree.sv */
// Harris parallel-prefix carry network built from black and grey cells

`timescale 1ns/1ns
`default_nettype none

`include "adder_consts.svh"

module harris_prefix_tree (
	input  logic [`ADDER_WIDTH-1:0] p,
	input  logic [`ADDER_WIDTH-1:0] g,
	output logic [`ADDER_WIDTH:1]   c
);

	localparam int W = `ADDER_WIDTH;
	localparam int STAGES = 5;

	// Level 0 holds the bitwise terms, levels 1 to 5 the odd-position groups
	logic [W-1:0] gt [0:STAGES];
	logic [W-1:0] pt [0:STAGES];

	// Returns {group generate, group propagate}
	function automatic logic [1:0] black_cell(input logic gh, input logic ph,
		input logic gl, input logic pl);
		black_cell = {gh | (ph & gl), ph & pl};
	endfunction

	// Lower group already reaches bit 0, so only generate matters
	function automatic logic grey_cell(input logic gh, input logic ph, input logic gl);
		grey_cell = gh | (ph & gl);
	endfunction

	assign gt[0] = g;
	assign pt[0] = p;

	// Sparse tree on odd positions, spans 1, 2, 4, 8 and 16
	for (genvar s = 1; s <= STAGES; s++) begin : gen_stage
		localparam int D = 1 << (s - 1);

		for (genvar i = 0; i < W; i++) begin : gen_bit
			if ((i % 2 == 1) && (i >= D)) begin : gen_cell
				if (i < 2 * D) begin : gen_grey
					assign gt[s][i] = grey_cell(gt[s-1][i], pt[s-1][i], gt[s-1][i-D]);
					assign pt[s][i] = pt[s-1][i];
				end else begin : gen_black
					assign {gt[s][i], pt[s][i]} = black_cell(gt[s-1][i], pt[s-1][i],
						gt[s-1][i-D], pt[s-1][i-D]);
				end
			end else begin : gen_pass
				// Even positions and finished groups ride through
				assign gt[s][i] = gt[s-1][i];
				assign pt[s][i] = pt[s-1][i];
			end
		end
	end

	// Fill row for even positions, then c[k+1] = G[k:0]
	for (genvar k = 0; k < W; k++) begin : gen_carry
		if (k == 0) begin : gen_lsb
			assign c[1] = g[0];
		end else if (k % 2 == 1) begin : gen_odd
			assign c[k+1] = gt[STAGES][k];
		end else begin : gen_even
			assign c[k+1] = grey_cell(g[k], p[k], gt[STAGES][k-1]);
		end
	end

endmodule

`default_nettype wire

/* hw/adder_pkg.sv */
// Compound adder package with operation codes and request, issue, lane and result types

`default_nettype none

`include "adder_consts.svh"

package adder_pkg;

	// Operations supported by the compound adder
	typedef enum logic [1:0] {
		OP_ADD     = 2'b00,
		OP_ADD_INC = 2'b01,
		OP_SUB     = 2'b10,
		OP_MAG     = 2'b11
	} op_t;

	// Request as presented by the source
	typedef struct packed {
		logic [`ADDER_WIDTH-1:0] a;
		logic [`ADDER_WIDTH-1:0] b;
		op_t                     op;
		logic [`TAG_WIDTH-1:0]   tag;
	} add_req_t;

	// Request at the queue head, b already inverted for subtraction
	typedef struct packed {
		logic [`ADDER_WIDTH-1:0] a;
		logic [`ADDER_WIDTH-1:0] b;
		op_t                     op;
		logic [`TAG_WIDTH-1:0]   tag;
	} issue_t;

	typedef struct packed {
		logic [`ADDER_WIDTH-1:0] sum;
		logic                    cout;
	} lane_out_t;

	typedef struct packed {
		logic [`ADDER_WIDTH-1:0] sum;
		logic                    carry;
		logic                    neg;
		logic [`TAG_WIDTH-1:0]   tag;
	} add_res_t;

endpackage

`default_nettype wire

/* hw/adder_consts.svh */
// Compound adder constants for significand width, tag width and credit depth

`ifndef ADDER_CONSTS_SVH
`define ADDER_CONSTS_SVH

// Significand width, fixed by the explicit Harris tree topology
`define ADDER_WIDTH 26

// Request identifier carried through to the result
`define TAG_WIDTH 4

// Input queue depth and initial output credit grant
`define CREDIT_DEPTH 4

`endif
